// ==== logic/buf_defs.svh ====
// buffer geometry macros, included by the RTL and the testbench
`ifndef BUF_DEFS_SVH
`define BUF_DEFS_SVH

`define CELL_COUNT 16

`define IDX_W 4

// seven payload beats plus one footer beat per 64-byte cell
`define PAYLOAD_BEATS 7

`define BEAT_W 64

`endif

// ==== logic/cell_pkg.sv ====
// storage format of a buffer cell, imported by the memory and both cell controllers
`include "buf_defs.svh"

package cell_pkg;

    localparam int FTR_RSVD_W = `BEAT_W - 5 - `IDX_W;

    typedef struct packed {
        logic                  valid;
        logic                  eop;        // last cell of the packet
        logic [2:0]            last_beats; // payload beats used, 1..7
        logic [`IDX_W-1:0]     next_idx;   // don't care at eop
        logic [FTR_RSVD_W-1:0] rsvd;
    } footer_t;

    typedef struct packed {
        logic [0:`PAYLOAD_BEATS-1][`BEAT_W-1:0] payload; // beat 0 in the top bits
        footer_t                                footer;
    } cell_fields_t;

    // one 512-bit cell word seen two ways
    typedef union packed {
        cell_fields_t                         fields; // writer view
        logic [0:`PAYLOAD_BEATS][`BEAT_W-1:0] beats;  // reader view, beats[7] is the footer
    } cell_u;

endpackage

// ==== logic/regs_pkg.sv ====
// APB register map of the packet buffer, shared by the register block and the testbench
package regs_pkg;

    localparam int CTRL_ENABLE_BIT = 0;

    // byte addresses on the 8-bit APB address bus
    typedef enum logic [7:0] {
        CTRL     = 8'h00, // enable, resets to 1
        FREE_CNT = 8'h04, // read only
        PKT_IN   = 8'h08, // packets stored, wraps at 16 bits
        PKT_OUT  = 8'h0C  // packets sent, wraps at 16 bits
    } reg_addr_e;

endpackage

// ==== logic/free_list.sv ====
// stack of free cell indices, popped by the writer and pushed back by the reader
`timescale 1ns/1ps
`include "buf_defs.svh"

module free_list (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_req_i,
    output logic              alloc_gnt_o,
    output logic [`IDX_W-1:0] alloc_idx_o,
    input  logic              rel_valid_i,
    input  logic [`IDX_W-1:0] rel_idx_i,
    output logic [`IDX_W:0]   free_cnt_o
);
    logic [`IDX_W-1:0] stack_q [`CELL_COUNT];
    logic [`IDX_W:0]   cnt_q;
    logic [`IDX_W-1:0] top_ptr;
    logic              gnt_dup; // granted index also free further down

    assign top_ptr     = cnt_q[`IDX_W-1:0] - 1'b1; // wraps to the last slot when full
    assign alloc_gnt_o = alloc_req_i && (cnt_q != '0);
    assign alloc_idx_o = stack_q[top_ptr];
    assign free_cnt_o  = cnt_q;

    // every cell starts out free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CELL_COUNT; i++) begin
                stack_q[i] <= `IDX_W'(i);
            end
            cnt_q <= (`IDX_W+1)'(`CELL_COUNT);
        end else begin
            if (alloc_gnt_o && rel_valid_i) begin
                stack_q[top_ptr] <= rel_idx_i; // swap on top, count unchanged
            end else if (alloc_gnt_o) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (rel_valid_i) begin
                stack_q[cnt_q[`IDX_W-1:0]] <= rel_idx_i;
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        gnt_dup = 1'b0;
        for (int i = 0; i < `CELL_COUNT; i++) begin
            if ((i < int'(top_ptr)) && (stack_q[i] == alloc_idx_o)) begin
                gnt_dup = 1'b1;
            end
        end
    end

    // reader can only return a cell the writer took
    a_no_rel_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid_i |-> cnt_q < (`IDX_W+1)'(`CELL_COUNT));

    // a cell released twice would show up twice in the stack
    a_gnt_unique: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_gnt_o |-> !gnt_dup);

endmodule

// ==== logic/cell_mem.sv ====
// dual-port cell storage, written whole by the writer and read whole by the reader
`timescale 1ns/1ps
`include "buf_defs.svh"

module cell_mem
    import cell_pkg::*;
(
    input  logic              clk,
    input  logic              wr_en_i,
    input  logic [`IDX_W-1:0] wr_idx_i,
    input  cell_u             wr_cell_i,
    input  logic              rd_en_i,
    input  logic [`IDX_W-1:0] rd_idx_i,
    output cell_u             rd_cell_o
);
    cell_u mem_q [`CELL_COUNT];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_cell_i;
        end
        if (rd_en_i) begin
            rd_cell_o <= mem_q[rd_idx_i]; // held until the next read
        end
    end

endmodule

// ==== logic/cell_write_ctrl.sv ====
// packs the input beat stream into linked cells and announces each finished packet
`timescale 1ns/1ps
`include "buf_defs.svh"

module cell_write_ctrl
    import cell_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable_i,
    input  logic [`BEAT_W-1:0] in_data_i,
    input  logic               in_valid_i,
    input  logic               in_begin_i,
    input  logic               in_end_i,
    output logic               in_ready_o,
    output logic               alloc_req_o,
    input  logic               alloc_gnt_i,
    input  logic [`IDX_W-1:0]  alloc_idx_i,
    output logic               wr_en_o,
    output logic [`IDX_W-1:0]  wr_idx_o,
    output cell_u              wr_cell_o,
    output logic               desc_valid_o,
    output logic [`IDX_W-1:0]  desc_head_o,
    output logic               pkt_in_o
);
    typedef enum logic [1:0] {IDLE_ALLOC, FILL, WAIT_NEXT, WRITE_CELL} state_e;

    state_e                                 state_q;
    logic [0:`PAYLOAD_BEATS-1][`BEAT_W-1:0] payload_q;
    logic [2:0]                             beat_cnt_q;
    logic [`IDX_W-1:0]                      cur_idx_q;
    logic [`IDX_W-1:0]                      next_idx_q;
    logic [`IDX_W-1:0]                      head_q;
    logic                                   eop_q;
    logic [2:0]                             last_beats_q;
    logic                                   in_pkt_q; // between begin and end beats
    logic                                   beat_xfer;
    logic                                   cell_full;

    assign beat_xfer  = in_valid_i && in_ready_o;
    assign cell_full  = beat_cnt_q == 3'(`PAYLOAD_BEATS - 1);
    assign in_ready_o = enable_i && (state_q == FILL);

    // ask on the seventh beat already, so a full cell goes out on the next edge
    assign alloc_req_o = (state_q == IDLE_ALLOC) || (state_q == WAIT_NEXT) ||
                         (beat_xfer && cell_full && !in_end_i);

    assign wr_en_o      = state_q == WRITE_CELL;
    assign wr_idx_o     = cur_idx_q;
    assign desc_valid_o = wr_en_o && eop_q; // same cycle as the eop cell write
    assign desc_head_o  = head_q;
    assign pkt_in_o     = desc_valid_o;

    always_comb begin
        wr_cell_o                          = '0;
        wr_cell_o.fields.payload           = payload_q;
        wr_cell_o.fields.footer.valid      = 1'b1;
        wr_cell_o.fields.footer.eop        = eop_q;
        wr_cell_o.fields.footer.last_beats = last_beats_q;
        wr_cell_o.fields.footer.next_idx   = next_idx_q;
    end

    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            payload_q[beat_cnt_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE_ALLOC;
            beat_cnt_q   <= '0;
            cur_idx_q    <= '0;
            next_idx_q   <= '0;
            head_q       <= '0;
            eop_q        <= 1'b0;
            last_beats_q <= '0;
            in_pkt_q     <= 1'b0;
        end else begin
            case (state_q)
                IDLE_ALLOC: begin
                    if (alloc_gnt_i) begin
                        cur_idx_q <= alloc_idx_i;
                        state_q   <= FILL;
                    end
                end
                FILL: begin
                    if (beat_xfer) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (in_begin_i) begin
                            head_q   <= cur_idx_q; // packet head for the reader
                            in_pkt_q <= 1'b1;
                        end
                        if (in_end_i) begin
                            in_pkt_q <= 1'b0;
                        end
                        if (alloc_gnt_i) begin
                            next_idx_q <= alloc_idx_i;
                        end
                        if (in_end_i || cell_full) begin
                            eop_q        <= in_end_i;
                            last_beats_q <= beat_cnt_q + 1'b1;
                            state_q      <= (in_end_i || alloc_gnt_i) ? WRITE_CELL : WAIT_NEXT;
                        end
                    end
                end
                WAIT_NEXT: begin // free list ran dry, input held off
                    if (alloc_gnt_i) begin
                        next_idx_q <= alloc_idx_i;
                        state_q    <= WRITE_CELL;
                    end
                end
                WRITE_CELL: begin
                    beat_cnt_q <= '0;
                    if (eop_q) begin
                        state_q <= IDLE_ALLOC;
                    end else begin
                        cur_idx_q <= next_idx_q; // continue in the linked cell
                        state_q   <= FILL;
                    end
                end
                default: state_q <= IDLE_ALLOC;
            endcase
        end
    end

    // a packet may only open in slot 0 of a cell that no open packet owns
    a_begin_fresh_cell: assert property (@(posedge clk) disable iff (!rst_n)
        (beat_xfer && in_begin_i) |-> (beat_cnt_q == '0) && !in_pkt_q);

endmodule

// ==== logic/cell_read_ctrl.sv ====
// walks the cell chain of each stored packet, streams it out and frees its cells
`timescale 1ns/1ps
`include "buf_defs.svh"

module cell_read_ctrl
    import cell_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               desc_valid_i,
    input  logic [`IDX_W-1:0]  desc_head_i,
    output logic               rd_en_o,
    output logic [`IDX_W-1:0]  rd_idx_o,
    input  cell_u              rd_cell_i,
    output logic [`BEAT_W-1:0] out_data_o,
    output logic               out_valid_o,
    output logic               out_begin_o,
    output logic               out_end_o,
    input  logic               out_ready_i,
    output logic               rel_valid_o,
    output logic [`IDX_W-1:0]  rel_idx_o,
    output logic               pkt_out_o
);
    typedef enum logic [1:0] {FETCH, WAIT_RD, EMIT} state_e;

    state_e            state_q;
    logic [`IDX_W-1:0] head_fifo_q [`CELL_COUNT];
    logic [`IDX_W-1:0] q_wr_ptr_q;
    logic [`IDX_W-1:0] q_rd_ptr_q;
    logic [`IDX_W:0]   q_cnt_q;
    logic              active_q; // mid-chain, cur_idx_q is the next cell to read
    logic [`IDX_W-1:0] cur_idx_q;
    logic              first_q;
    logic [2:0]        beat_q;
    footer_t           ftr_q;
    logic              q_pop;
    logic              last_beat;
    logic              beat_xfer;

    assign q_pop    = (state_q == FETCH) && !active_q && (q_cnt_q != '0);
    assign rd_en_o  = (state_q == FETCH) && (active_q || (q_cnt_q != '0));
    assign rd_idx_o = active_q ? cur_idx_q : head_fifo_q[q_rd_ptr_q];

    assign last_beat   = beat_q == ftr_q.last_beats - 3'd1;
    assign out_valid_o = state_q == EMIT;
    assign out_data_o  = rd_cell_i.beats[beat_q]; // memory output holds while emitting
    assign out_begin_o = first_q && (beat_q == '0);
    assign out_end_o   = ftr_q.eop && last_beat;
    assign beat_xfer   = out_valid_o && out_ready_i;
    assign rel_valid_o = beat_xfer && last_beat;
    assign rel_idx_o   = cur_idx_q;
    assign pkt_out_o   = rel_valid_o && ftr_q.eop;

    always_ff @(posedge clk) begin
        if (desc_valid_i) begin
            head_fifo_q[q_wr_ptr_q] <= desc_head_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= FETCH;
            q_wr_ptr_q <= '0;
            q_rd_ptr_q <= '0;
            q_cnt_q    <= '0;
            active_q   <= 1'b0;
            cur_idx_q  <= '0;
            first_q    <= 1'b0;
            beat_q     <= '0;
            ftr_q      <= '0;
        end else begin
            if (desc_valid_i) begin
                q_wr_ptr_q <= q_wr_ptr_q + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr_q <= q_rd_ptr_q + 1'b1;
            end
            q_cnt_q <= q_cnt_q + (`IDX_W+1)'(desc_valid_i) - (`IDX_W+1)'(q_pop);

            case (state_q)
                FETCH: begin
                    if (q_pop) begin // new packet from the queue
                        cur_idx_q <= head_fifo_q[q_rd_ptr_q];
                        first_q   <= 1'b1;
                        active_q  <= 1'b1;
                    end
                    if (rd_en_o) begin
                        state_q <= WAIT_RD;
                    end
                end
                WAIT_RD: begin
                    ftr_q   <= footer_t'(rd_cell_i.beats[`PAYLOAD_BEATS]);
                    beat_q  <= '0;
                    state_q <= EMIT;
                end
                EMIT: begin
                    if (beat_xfer) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            first_q   <= 1'b0;
                            cur_idx_q <= ftr_q.next_idx; // follow the link
                            active_q  <= !ftr_q.eop;
                            state_q   <= FETCH;
                        end
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // one entry per stored packet, and every packet holds at least one cell
    a_queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        desc_valid_i |-> q_cnt_q < (`IDX_W+1)'(`CELL_COUNT));

endmodule

// ==== logic/apb_regs.sv ====
// APB slave with the enable bit, the packet counters and the free cell count
`timescale 1ns/1ps
`include "buf_defs.svh"

module apb_regs
    import regs_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [7:0]       paddr_i,
    input  logic [31:0]      pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  logic [`IDX_W:0]  free_cnt_i,
    input  logic             pkt_in_i,
    input  logic             pkt_out_i,
    output logic             enable_o
);
    reg_addr_e   addr;
    logic        mapped;
    logic        access;
    logic        enable_q;
    logic [15:0] pkt_in_cnt_q;
    logic [15:0] pkt_out_cnt_q;

    assign addr     = reg_addr_e'(paddr_i);
    assign access   = psel_i && penable_i;
    assign pready_o = 1'b1; // no wait states
    assign enable_o = enable_q;

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (addr)
            CTRL:     prdata_o[CTRL_ENABLE_BIT] = enable_q;
            FREE_CNT: prdata_o[`IDX_W:0] = free_cnt_i;
            PKT_IN:   prdata_o[15:0] = pkt_in_cnt_q;
            PKT_OUT:  prdata_o[15:0] = pkt_out_cnt_q;
            default:  mapped = 1'b0;
        endcase
    end

    // only CTRL is writable
    assign pslverr_o = access && (!mapped || (pwrite_i && (addr != CTRL)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q      <= 1'b1; // buffer runs out of reset
            pkt_in_cnt_q  <= '0;
            pkt_out_cnt_q <= '0;
        end else begin
            if (access && pwrite_i && (addr == CTRL)) begin
                enable_q <= pwdata_i[CTRL_ENABLE_BIT];
            end
            if (pkt_in_i) begin
                pkt_in_cnt_q <= pkt_in_cnt_q + 16'd1;
            end
            if (pkt_out_i) begin
                pkt_out_cnt_q <= pkt_out_cnt_q + 16'd1;
            end
        end
    end

endmodule

// ==== logic/pkt_buffer_top.sv ====
// linked-cell packet buffer top, wiring the controllers, free list, memory and registers
`timescale 1ns/1ps
`include "buf_defs.svh"

module pkt_buffer_top
    import cell_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`BEAT_W-1:0] in_data_i,
    input  logic               in_valid_i,
    input  logic               in_begin_i,
    input  logic               in_end_i,
    output logic               in_ready_o,
    output logic [`BEAT_W-1:0] out_data_o,
    output logic               out_valid_o,
    output logic               out_begin_o,
    output logic               out_end_o,
    input  logic               out_ready_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [7:0]         paddr_i,
    input  logic [31:0]        pwdata_i,
    output logic [31:0]        prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);
    logic              alloc_req;
    logic              alloc_gnt;
    logic [`IDX_W-1:0] alloc_idx;
    logic              rel_valid;
    logic [`IDX_W-1:0] rel_idx;
    logic [`IDX_W:0]   free_cnt;
    logic              wr_en;
    logic [`IDX_W-1:0] wr_idx;
    cell_u             wr_cell;
    logic              rd_en;
    logic [`IDX_W-1:0] rd_idx;
    cell_u             rd_cell;
    logic              desc_valid;
    logic [`IDX_W-1:0] desc_head;
    logic              pkt_in;
    logic              pkt_out;
    logic              enable;

    free_list u_free_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_req_i (alloc_req),
        .alloc_gnt_o (alloc_gnt),
        .alloc_idx_o (alloc_idx),
        .rel_valid_i (rel_valid),
        .rel_idx_i   (rel_idx),
        .free_cnt_o  (free_cnt)
    );

    cell_mem u_cell_mem (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_cell_i (wr_cell),
        .rd_en_i   (rd_en),
        .rd_idx_i  (rd_idx),
        .rd_cell_o (rd_cell)
    );

    cell_write_ctrl u_write_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable_i     (enable),
        .in_data_i    (in_data_i),
        .in_valid_i   (in_valid_i),
        .in_begin_i   (in_begin_i),
        .in_end_i     (in_end_i),
        .in_ready_o   (in_ready_o),
        .alloc_req_o  (alloc_req),
        .alloc_gnt_i  (alloc_gnt),
        .alloc_idx_i  (alloc_idx),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_cell_o    (wr_cell),
        .desc_valid_o (desc_valid),
        .desc_head_o  (desc_head),
        .pkt_in_o     (pkt_in)
    );

    cell_read_ctrl u_read_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .desc_valid_i (desc_valid),
        .desc_head_i  (desc_head),
        .rd_en_o      (rd_en),
        .rd_idx_o     (rd_idx),
        .rd_cell_i    (rd_cell),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o),
        .out_begin_o  (out_begin_o),
        .out_end_o    (out_end_o),
        .out_ready_i  (out_ready_i),
        .rel_valid_o  (rel_valid),
        .rel_idx_o    (rel_idx),
        .pkt_out_o    (pkt_out)
    );

    apb_regs u_apb_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .free_cnt_i (free_cnt),
        .pkt_in_i   (pkt_in),
        .pkt_out_i  (pkt_out),
        .enable_o   (enable)
    );

endmodule

// ==== verif/tb_pkt_buffer.sv ====
// directed testbench for the packet buffer, run as the simulation top with the RTL file list
`timescale 1ns/1ps
`include "buf_defs.svh"

module tb_pkt_buffer
    import regs_pkg::*;
();
    localparam int CLK_PERIOD = 100;
    localparam int MAX_CYCLES = 20000; // well over the summed test lengths of about 1000 cycles
    localparam int IDLE_FREE  = `CELL_COUNT - 1; // writer holds one pre-allocated cell

    logic               clk;
    logic               rst_n;
    logic [`BEAT_W-1:0] in_data_i;
    logic               in_valid_i;
    logic               in_begin_i;
    logic               in_end_i;
    logic               in_ready_o;
    logic [`BEAT_W-1:0] out_data_o;
    logic               out_valid_o;
    logic               out_begin_o;
    logic               out_end_o;
    logic               out_ready_i;
    logic               psel_i;
    logic               penable_i;
    logic               pwrite_i;
    logic [7:0]         paddr_i;
    logic [31:0]        pwdata_i;
    logic [31:0]        prdata_o;
    logic               pready_o;
    logic               pslverr_o;

    logic [31:0]        rng_q;
    logic [`BEAT_W-1:0] exp_q [$]; // beats accepted at the input, not yet seen at the output
    int                 pkts_sent;
    int                 pkts_recv;
    int                 err_cnt;
    int unsigned        cycle_cnt;
    int                 mixed_lens [6] = '{1, 7, 8, 14, 15, 3};

    pkt_buffer_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("TEST FAIL");
            $fatal(1, "run aborted");
        end
    end

    task automatic report_fail(input string what);
        err_cnt++;
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // 32-bit xorshift, shared by beat data and output stalls
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_q;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_q = x;
        return x;
    endfunction

    function automatic int cells_for(input int len);
        return (len + `PAYLOAD_BEATS - 1) / `PAYLOAD_BEATS;
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk);
        penable_i = 1'b1;
        #(CLK_PERIOD / 4); // mid access phase
        assert (pready_o) else report_fail("pready_o was low in the access phase");
        assert (pslverr_o == exp_err) else
            report_fail($sformatf("mismatch pslverr_o at %h exp %h got %h",
                                  addr, exp_err, pslverr_o));
        @(posedge clk);
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp_data);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(negedge clk);
        penable_i = 1'b1;
        #(CLK_PERIOD / 4);
        assert (pready_o) else report_fail("pready_o was low in the access phase");
        assert (prdata_o == exp_data) else
            report_fail($sformatf("mismatch prdata_o at %h exp %h got %h",
                                  addr, exp_data, prdata_o));
        assert (!pslverr_o) else report_fail("a read of a mapped register raised pslverr_o");
        @(posedge clk);
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic send_pkt(input int len);
        logic [`BEAT_W-1:0] beat;
        for (int i = 0; i < len; i++) begin
            beat = {next_random(), next_random()};
            @(negedge clk);
            in_valid_i = 1'b1;
            in_data_i  = beat;
            in_begin_i = (i == 0);
            in_end_i   = (i == len - 1);
            while (!in_ready_o) @(negedge clk); // held until the writer takes it
            @(posedge clk);
            exp_q.push_back(beat);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        in_begin_i = 1'b0;
        in_end_i   = 1'b0;
        pkts_sent++;
    endtask

    task automatic recv_pkt_check(input int len, input bit random_ready);
        logic [`BEAT_W-1:0] exp_beat;
        logic [31:0]        r;
        int                 got;
        got = 0;
        while (got < len) begin
            @(negedge clk);
            r = next_random();
            out_ready_i = random_ready ? r[0] : 1'b1;
            if (out_valid_o && out_ready_i) begin // transfers on the coming edge
                assert (exp_q.size() > 0) else
                    report_fail("an output beat arrived while no beat was expected");
                exp_beat = exp_q.pop_front();
                assert (out_data_o == exp_beat) else
                    report_fail($sformatf("mismatch out_data_o exp %h got %h",
                                          exp_beat, out_data_o));
                assert (out_begin_o == (got == 0)) else
                    report_fail($sformatf("mismatch out_begin_o exp %h got %h",
                                          got == 0, out_begin_o));
                assert (out_end_o == (got == len - 1)) else
                    report_fail($sformatf("mismatch out_end_o exp %h got %h",
                                          got == len - 1, out_end_o));
                got++;
            end
        end
        @(negedge clk);
        out_ready_i = 1'b0;
        pkts_recv++;
    endtask

    task automatic wait_writer_ready();
        do @(negedge clk); while (!in_ready_o);
    endtask

    task automatic reset_values();
        apb_read_check(FREE_CNT, 32'(IDLE_FREE));
        apb_read_check(PKT_IN, 32'd0);
        apb_read_check(PKT_OUT, 32'd0);
        apb_read_check(CTRL, 32'd1);
        apb_write(FREE_CNT, 32'd5, 1'b1); // read only
    endtask

    task automatic short_packet();
        send_pkt(3);
        recv_pkt_check(3, 1'b0);
        apb_read_check(FREE_CNT, 32'(IDLE_FREE));
    endtask

    task automatic held_packet();
        send_pkt(20);
        wait_writer_ready();
        apb_read_check(FREE_CNT, 32'(IDLE_FREE - cells_for(20)));
        recv_pkt_check(20, 1'b0);
        apb_read_check(FREE_CNT, 32'(IDLE_FREE));
    endtask

    task automatic mixed_lengths();
        fork
            foreach (mixed_lens[i]) send_pkt(mixed_lens[i]);
            foreach (mixed_lens[i]) recv_pkt_check(mixed_lens[i], 1'b1);
        join
        wait_writer_ready();
        apb_read_check(FREE_CNT, 32'(IDLE_FREE));
    endtask

    task automatic input_backpressure();
        apb_write(CTRL, 32'd0, 1'b0);
        apb_read_check(CTRL, 32'd0);
        fork
            send_pkt(5);
            begin
                repeat (10) begin
                    @(negedge clk);
                    assert (!in_ready_o) else report_fail("input accepted while disabled");
                end
                apb_write(CTRL, 32'd1, 1'b0);
            end
        join
        recv_pkt_check(5, 1'b0);

        send_pkt(`CELL_COUNT * `PAYLOAD_BEATS); // every cell in use
        fork
            send_pkt(10);
            begin
                repeat (20) begin
                    @(negedge clk);
                    assert (!in_ready_o) else report_fail("input accepted with no free cell");
                end
                apb_read_check(FREE_CNT, 32'd0);
                recv_pkt_check(`CELL_COUNT * `PAYLOAD_BEATS, 1'b1);
                recv_pkt_check(10, 1'b1);
            end
        join
        wait_writer_ready();
        apb_read_check(FREE_CNT, 32'(IDLE_FREE));
    endtask

    task automatic packet_counters();
        apb_read_check(PKT_IN, 32'(pkts_sent));
        apb_read_check(PKT_OUT, 32'(pkts_recv));
        assert (exp_q.size() == 0) else report_fail("expected beats never came out");
    endtask

    initial begin
        rng_q       = 32'h49076dab;
        pkts_sent   = 0;
        pkts_recv   = 0;
        err_cnt     = 0;
        cycle_cnt   = 0;
        rst_n       = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        in_begin_i  = 1'b0;
        in_end_i    = 1'b0;
        out_ready_i = 1'b0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        short_packet();
        held_packet();
        mixed_lengths();
        input_backpressure();
        packet_counters();

        if (err_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "%0d checks failed", err_cnt);
        end
    end

endmodule

// ==== Makefile ====
# Verilator build for the packet buffer: lint, sim and clean

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_pkt_buffer
RTL_TOP   ?= pkt_buffer_top
BUILD_DIR ?= obj_dir
LOG_FILE  ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG_FILE)
	grep -q "TEST PASS" $(LOG_FILE)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)

// ==== sources.f ====
+incdir+logic
logic/cell_pkg.sv
logic/regs_pkg.sv
logic/free_list.sv
logic/cell_mem.sv
logic/cell_write_ctrl.sv
logic/cell_read_ctrl.sv
logic/apb_regs.sv
logic/pkt_buffer_top.sv
verif/tb_pkt_buffer.sv
